/* project.f */
common/obj_cfg_pkg.sv
common/obj_types_pkg.sv
obj_scan/obj_scan.sv
obj_draw/obj_draw.sv
verilog/obj_line_buffer.sv
verilog/obj_engine.sv
tb/obj_engine_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the object engine testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 --top-module obj_engine_tb \
    -f project.f -o obj_engine_sim > build.log 2>&1 \
    && ./obj_dir/obj_engine_sim > sim.log 2>&1 \
    || echo "build or simulation error, see build.log and sim.log"

cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* tb/obj_engine_tb.sv */
// object engine testbench
// clock and reset, attribute RAM and graphics ROM models,
// stimulus table with a reference line renderer,
// pixel and graphics request checks, watchdog
module obj_engine_tb;
    import obj_cfg_pkg::*;
    import obj_types_pkg::*;

    localparam int SCREEN_W    = 320;
    localparam int NUM_TESTS   = 6;
    localparam int MAX_SPR     = 4;
    localparam int LINE_CYCLES = LINE_W * 8;     // pixel enable every 8 clocks
    localparam longint TIMEOUT = longint'(16 + 600 + (NUM_TESTS * 3 + 3) * LINE_CYCLES) * 20;

    typedef struct packed {
        logic [7:0]  idx;                        // attribute RAM entry
        logic [15:0] w0, w1, w2, w3;
    } attr_entry_t;

    typedef struct packed {
        logic [8:0] vrender;
        logic [8:0] scroll_x;
        logic [8:0] scroll_y;
    } test_cfg_t;

    logic         CLK96 = 1'b0;
    logic         RESET96, pixel_cen_i, active_i, hblank_i, vblank_i;
    logic [8:0]   vrender_i, h_i, scroll_x_i, scroll_y_i;
    logic [9:0]   attr_addr_o;
    logic [15:0]  attr_data_i = '0;
    logic         gfx_cs_o, gfx_ok_i;
    logic [31:0]  gfx_data_i;
    gfx_req_t     gfx_req_o;
    obj_pixel_t   obj_pixel_o;

    logic [15:0]  attr_ram [SPRITE_COUNT * WORDS_PER_SPRITE];
    attr_entry_t  spr_tab [NUM_TESTS][MAX_SPR];
    test_cfg_t    cfg_tab [NUM_TESTS];
    string        name_tab [NUM_TESTS];
    obj_pixel_t   ref_line [LINE_W];
    obj_pixel_t   exp_line [LINE_W];
    gfx_req_t     exp_reqs [$];                  // requests in issue order
    logic [7:0]   lfsr = 8'd82;
    int           gfx_wait = 0;
    int           checks = 0;
    int           errors = 0;

    obj_engine #(
        .SCREEN_W(SCREEN_W), .PRI_LEVELS(DEF_PRI_LEVELS), .QUEUE_DEPTH(DEF_QUEUE_DEPTH)
    ) dut0 (.*);

    always #10 CLK96 = ~CLK96;

    always @(posedge CLK96) attr_data_i <= attr_ram[attr_addr_o];   // 1-cycle read

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};  // taps 8,6,5,4
    endfunction

    // graphics ROM contents with some transparent nibbles in every slice
    function automatic logic [31:0] slice_word(input logic [14:0] tile, input logic [15:0] offs);
        logic [31:0] w;
        for (int k = 0; k < 8; k++) w[4*k +: 4] = 4'((int'(tile) + int'(offs) + 3 * k) % 7);
        return w;
    endfunction

    function automatic attr_entry_t make_entry(input int idx, act, yf, xf, pri, pal, bank,
                                               input int tile, x, xs, y, ys);
        attr_entry_t e;
        e.idx = 8'(idx);
        e.w0  = {act[0], 1'b0, yf[0], xf[0], pri[3:0], pal[5:0], bank[1:0]};
        e.w1  = {1'b0, tile[14:0]};
        e.w2  = {x[8:0], 3'b000, xs[3:0]};
        e.w3  = {y[8:0], 3'b000, ys[3:0]};
        return e;
    endfunction

    task automatic check_pixel(input obj_pixel_t got, input obj_pixel_t exp, input int h);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED obj_pixel_o at h=%0d: got %h, expected %h", h, got, exp);
        end
    endtask

    task automatic check_gfx_req(input gfx_req_t got);
        gfx_req_t exp;
        checks++;
        if (exp_reqs.size() == 0) begin
            errors++;
            $display("unexpected graphics request for tile %h offset %h", got.tile, got.offset);
        end else begin
            exp = exp_reqs.pop_front();
            if (got !== exp) begin
                errors++;
                $display("CHECK FAILED gfx_req_o: got %h, expected %h", got, exp);
            end
        end
    endtask

    task automatic fill_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            cfg_tab[t] = {9'd100, 9'd0, 9'd0};
            for (int s = 0; s < MAX_SPR; s++) spr_tab[t][s] = '0;   // entry 0 left unused
        end
        name_tab[0] = "single sprite";
        spr_tab[0][0] = make_entry(10, 1, 0, 0, 3, 'h15, 1, 'h123, 40, 1, 96, 0);
        name_tab[1] = "inactive and off-line";
        spr_tab[1][0] = make_entry(5, 0, 0, 0, 7, 'h03, 0, 'h020, 60, 1, 98, 0);
        spr_tab[1][1] = make_entry(6, 1, 0, 0, 7, 'h03, 0, 'h021, 100, 0, 120, 0);
        spr_tab[1][2] = make_entry(7, 1, 0, 0, 7, 'h03, 0, 'h022, 140, 0, 80, 1);
        name_tab[2] = "x and y flip";
        spr_tab[2][0] = make_entry(20, 1, 1, 1, 5, 'h02, 2, 'h456, 200, 2, 90, 1);
        spr_tab[2][1] = make_entry(21, 1, 0, 1, 6, 'h0a, 3, 'h457, 100, 0, 97, 0);
        spr_tab[2][2] = make_entry(22, 1, 1, 0, 4, 'h11, 0, 'h458, 16, 1, 95, 0);
        name_tab[3] = "priority overlap";
        spr_tab[3][0] = make_entry(1, 1, 0, 0, 9, 'h21, 0, 'h300, 50, 1, 100, 0);
        spr_tab[3][1] = make_entry(3, 1, 0, 0, 2, 'h05, 0, 'h301, 54, 1, 99, 0);
        spr_tab[3][2] = make_entry(30, 1, 0, 0, 4, 'h30, 1, 'h302, 150, 0, 98, 0);
        spr_tab[3][3] = make_entry(40, 1, 0, 0, 12, 'h06, 1, 'h303, 146, 1, 96, 0);
        name_tab[4] = "scroll and clip";
        cfg_tab[4]    = {9'd100, 9'd30, 9'd500};  // scroll y of -12
        spr_tab[4][0] = make_entry(50, 1, 0, 0, 8, 'h1f, 0, 'h500, 280, 3, 110, 0);
        spr_tab[4][1] = make_entry(51, 1, 0, 1, 3, 'h2c, 2, 'h501, 490, 1, 104, 1);
        spr_tab[4][2] = make_entry(52, 1, 0, 0, 3, 'h01, 0, 'h502, 100, 0, 100, 0);
        spr_tab[4][3] = make_entry(53, 1, 0, 0, 5, 'h07, 1, 'h503, 470, 2, 105, 1);
        name_tab[5] = "empty RAM";
    endtask

    task automatic clear_ram();
        for (int i = 0; i < SPRITE_COUNT * WORDS_PER_SPRITE; i++) attr_ram[i] = '0;
    endtask

    // expected line and requests from the layout, scroll, flip and clip rules
    task automatic render_reference(input test_cfg_t cfg);
        logic [15:0] w0, w1, w2, w3, offs;
        logic [8:0]  row, xpos;
        logic [31:0] word;
        gfx_req_t    req;
        obj_pixel_t  pix;
        int          height, xs, x;
        for (int i = 0; i < LINE_W; i++) ref_line[i] = '0;
        exp_reqs.delete();
        for (int p = 0; p < DEF_PRI_LEVELS; p++) begin         // lowest level drawn first
            for (int s = 0; s < SPRITE_COUNT; s++) begin
                w0     = attr_ram[s * 4];
                w1     = attr_ram[s * 4 + 1];
                w2     = attr_ram[s * 4 + 2];
                w3     = attr_ram[s * 4 + 3];
                row    = cfg.vrender - (w3[15:7] + cfg.scroll_y);
                height = 8 * (int'(w3[3:0]) + 1);
                xs     = int'(w2[3:0]);
                xpos   = w2[15:7] + cfg.scroll_x;
                if (w0[15] && int'(w0[11:8]) == p && int'(row) < height) begin
                    if (w0[13]) row = 9'(height - 1 - int'(row));
                    for (int c = 0; c <= xs; c++) begin
                        offs = 16'(int'(row) / 8 * (xs + 1) * 32 + c * 32 + int'(row) % 8 * 4);
                        req  = {w1[14:0], offs, w0[1:0]};
                        exp_reqs.push_back(req);
                        word = slice_word(w1[14:0], offs);
                        for (int k = 0; k < 8; k++) begin
                            x   = w0[12] ? int'(xpos) + 8 * (xs - c) + 7 - k
                                         : int'(xpos) + 8 * c + k;
                            x   = x % LINE_W;
                            pix = {w0[11:8], w0[7:2], word[4*k +: 4]};
                            if (pix.code != 4'd0 && x < SCREEN_W) ref_line[x] = pix;
                        end
                    end
                end
            end
        end
    endtask

    task automatic load_test(input int t);
        clear_ram();
        for (int s = 0; s < MAX_SPR; s++) begin
            attr_ram[int'(spr_tab[t][s].idx) * 4]     = spr_tab[t][s].w0;
            attr_ram[int'(spr_tab[t][s].idx) * 4 + 1] = spr_tab[t][s].w1;
            attr_ram[int'(spr_tab[t][s].idx) * 4 + 2] = spr_tab[t][s].w2;
            attr_ram[int'(spr_tab[t][s].idx) * 4 + 3] = spr_tab[t][s].w3;
        end
        vrender_i  = cfg_tab[t].vrender;
        scroll_x_i = cfg_tab[t].scroll_x;
        scroll_y_i = cfg_tab[t].scroll_y;
        render_reference(cfg_tab[t]);
    endtask

    // graphics ROM model answering each request after 1 to 4 cycles
    task automatic gfx_respond();
        if (gfx_ok_i) begin
            gfx_ok_i = 1'b0;
        end else if (gfx_cs_o) begin
            if (gfx_wait == 0) begin
                lfsr     = lfsr_step(lfsr);
                gfx_wait = 1 + int'(lfsr[0]);
                lfsr     = lfsr_step(lfsr);
                gfx_wait = gfx_wait + 2 * int'(lfsr[0]);
            end
            gfx_wait--;
            if (gfx_wait == 0) begin
                check_gfx_req(gfx_req_o);
                gfx_data_i = slice_word(gfx_req_o.tile, gfx_req_o.offset);
                gfx_ok_i   = 1'b1;
            end
        end
    endtask

    // one video line with hblank falling at h=0 so the bank swap precedes the first read
    // the whole line plays out and clipped positions must read back empty
    task automatic run_line(input bit show_ref);
        for (int i = 0; i < LINE_W; i++) exp_line[i] = show_ref ? ref_line[i] : obj_pixel_t'(0);
        for (int h = 0; h < LINE_W; h++) begin
            for (int sub = 0; sub < 8; sub++) begin
                @(negedge CLK96);
                h_i         = 9'(h);
                pixel_cen_i = (sub == 4);
                active_i    = 1'b1;
                hblank_i    = (h >= SCREEN_W);
                if (sub == 5) check_pixel(obj_pixel_o, exp_line[h], h);
                gfx_respond();
            end
        end
    endtask

    initial begin
        int err_start;
        RESET96     = 1'b1;
        pixel_cen_i = 1'b0;
        active_i    = 1'b0;
        hblank_i    = 1'b1;
        vblank_i    = 1'b0;
        vrender_i   = 9'd0;
        h_i         = 9'd0;
        scroll_x_i  = 9'd0;
        scroll_y_i  = 9'd0;
        gfx_ok_i    = 1'b0;
        gfx_data_i  = '0;
        fill_table();
        clear_ram();
        repeat (16) @(negedge CLK96);
        RESET96 = 1'b0;
        repeat (600) @(negedge CLK96);           // start-up sweep of the line buffer
        run_line(1'b0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            err_start = errors;
            load_test(t);
            run_line(1'b0);                      // scan and draw while the previous bank plays out
            clear_ram();
            run_line(1'b1);
            run_line(1'b0);
            if (exp_reqs.size() != 0) begin
                errors++;
                $display("%0d expected graphics requests were never made", exp_reqs.size());
                exp_reqs.delete();
            end
            $display("test %0d %s: %0d errors", t, name_tab[t], errors - err_start);
        end
        run_line(1'b0);                          // last played bank must read back empty
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog timeout, the tests did not finish in time");
        $display("Checks failed");
        $finish;
    end

endmodule

/* verilog/obj_engine.sv */
// object layer top level
// line start detection from the blanking signals,
// scan unit, draw unit and line buffer instances
module obj_engine #(
    parameter int SCREEN_W    = obj_cfg_pkg::DEF_SCREEN_W,
    parameter int PRI_LEVELS  = obj_cfg_pkg::DEF_PRI_LEVELS,
    parameter int QUEUE_DEPTH = obj_cfg_pkg::DEF_QUEUE_DEPTH
) (
    input  logic                                CLK96,
    input  logic                                RESET96,
    input  logic                                pixel_cen_i,
    input  logic                                active_i,
    input  logic                                hblank_i,
    input  logic                                vblank_i,
    input  logic [obj_cfg_pkg::POS_BITS-1:0]    vrender_i,
    input  logic [obj_cfg_pkg::POS_BITS-1:0]    h_i,
    input  logic [obj_cfg_pkg::POS_BITS-1:0]    scroll_x_i,
    input  logic [obj_cfg_pkg::POS_BITS-1:0]    scroll_y_i,
    output logic [9:0]                          attr_addr_o,
    input  logic [15:0]                         attr_data_i,
    output logic                                gfx_cs_o,
    output obj_types_pkg::gfx_req_t             gfx_req_o,
    input  logic                                gfx_ok_i,
    input  logic [31:0]                         gfx_data_i,
    output obj_types_pkg::obj_pixel_t           obj_pixel_o
);
    import obj_cfg_pkg::*;
    import obj_types_pkg::*;

    logic                 hblank_d, line_start;
    logic                 spr_valid, draw_busy, wr_en;
    sprite_attr_t         spr;
    logic [POS_BITS-1:0]  wr_addr;
    obj_pixel_t           wr_pix;

    // end of horizontal blank outside vertical blank starts a line
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            hblank_d   <= 1'b0;
            line_start <= 1'b0;
        end else begin
            hblank_d   <= hblank_i;
            line_start <= hblank_d && !hblank_i && !vblank_i;
        end
    end

    obj_scan #(.PRI_LEVELS(PRI_LEVELS), .QUEUE_DEPTH(QUEUE_DEPTH)) u_scan (
        .CLK96, .RESET96,
        .line_start_i(line_start), .vrender_i, .scroll_x_i, .scroll_y_i,
        .attr_addr_o, .attr_data_i,
        .draw_busy_i(draw_busy), .spr_valid_o(spr_valid), .spr_o(spr)
    );

    obj_draw #(.SCREEN_W(SCREEN_W)) u_draw (
        .CLK96, .RESET96,
        .spr_valid_i(spr_valid), .spr_i(spr), .draw_busy_o(draw_busy),
        .gfx_cs_o, .gfx_req_o, .gfx_ok_i, .gfx_data_i,
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_pix_o(wr_pix)
    );

    obj_line_buffer u_line_buf (
        .CLK96, .RESET96,
        .line_start_i(line_start), .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_pix_i(wr_pix),
        .pixel_cen_i, .active_i, .h_i, .obj_pixel_o
    );

endmodule

/* verilog/obj_line_buffer.sv */
// double-buffered object line memory
// one bank takes draw writes while the other plays out
// at the horizontal counter and is cleared behind the read
module obj_line_buffer (
    input  logic                                CLK96,
    input  logic                                RESET96,
    input  logic                                line_start_i,
    input  logic                                wr_en_i,
    input  logic [obj_cfg_pkg::POS_BITS-1:0]    wr_addr_i,
    input  obj_types_pkg::obj_pixel_t           wr_pix_i,
    input  logic                                pixel_cen_i,
    input  logic                                active_i,
    input  logic [obj_cfg_pkg::POS_BITS-1:0]    h_i,
    output obj_types_pkg::obj_pixel_t           obj_pixel_o
);
    import obj_cfg_pkg::*;
    import obj_types_pkg::*;

    logic                 wr_bank;
    logic                 clearing;     // start-up sweep of both banks
    logic [POS_BITS-1:0]  clr_addr;
    logic                 rd_en;
    obj_pixel_t           rd_pix;

    assign rd_en = pixel_cen_i && active_i;

    for (genvar b = 0; b < 2; b++) begin : g_bank
        obj_pixel_t mem [LINE_W];

        always_ff @(posedge CLK96) begin
            if (clearing) mem[clr_addr] <= '0;
            else if (wr_en_i && wr_bank == 1'(b)) mem[wr_addr_i] <= wr_pix_i;
            else if (rd_en && wr_bank != 1'(b)) mem[h_i] <= '0;   // read and clear
        end
    end

    assign rd_pix = wr_bank ? g_bank[0].mem[h_i] : g_bank[1].mem[h_i];

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            wr_bank     <= 1'b0;
            clearing    <= 1'b1;
            clr_addr    <= '0;
            obj_pixel_o <= '0;
        end else begin
            if (line_start_i) wr_bank <= ~wr_bank;
            if (clearing) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == POS_BITS'(LINE_W - 1)) clearing <= 1'b0;
            end
            if (rd_en) obj_pixel_o <= rd_pix;
        end
    end

    // a write on the swap cycle would land in the bank about to play out
    a_no_rd_bank_wr: assert property (@(posedge CLK96) disable iff (RESET96)
        wr_en_i |-> !line_start_i && !clearing)
        else $error("object write hits the bank being read");

endmodule

/* obj_draw/obj_draw.sv */
// sprite draw unit
// walks the tile columns of one sprite, fetches a 32-bit slice
// per column and plots its eight pixels in flip order,
// clipped to the visible width
module obj_draw #(
    parameter int SCREEN_W = obj_cfg_pkg::DEF_SCREEN_W
) (
    input  logic                                CLK96,
    input  logic                                RESET96,
    input  logic                                spr_valid_i,
    input  obj_types_pkg::sprite_attr_t         spr_i,
    output logic                                draw_busy_o,
    output logic                                gfx_cs_o,
    output obj_types_pkg::gfx_req_t             gfx_req_o,
    input  logic                                gfx_ok_i,
    input  logic [31:0]                         gfx_data_i,
    output logic                                wr_en_o,
    output logic [obj_cfg_pkg::POS_BITS-1:0]    wr_addr_o,
    output obj_types_pkg::obj_pixel_t           wr_pix_o
);
    import obj_cfg_pkg::*;
    import obj_types_pkg::*;

    draw_state_t          state;
    sprite_attr_t         spr_q;
    logic [4:0]           col;          // tile column, up to 16
    logic [2:0]           nib;          // pixel inside the slice
    logic [31:0]          slice;

    logic [15:0]          tile_row, row_in_tile, tile_offs;
    logic [3:0]           col_sel;
    logic [2:0]           nib_sel;
    logic [POS_BITS-1:0]  pix_x;
    logic [3:0]           code;
    logic                 cols_done;

    assign tile_row    = 16'(spr_q.row / TILE_PIXELS);
    assign row_in_tile = 16'(spr_q.row % TILE_PIXELS);
    assign tile_offs   = (tile_row * (16'(spr_q.x_size) + 16'd1) + 16'(col)) * 16'(SLICE_STRIDE)
                         + row_in_tile * 16'd4;     // 4 offset units per slice row
    assign cols_done   = col > {1'b0, spr_q.x_size};

    // x flip mirrors both the column and the pixel order
    assign col_sel = spr_q.xflip ? spr_q.x_size - col[3:0] : col[3:0];
    assign nib_sel = spr_q.xflip ? ~nib : nib;
    assign pix_x   = spr_q.x_pos + {2'b00, col_sel, nib_sel};
    assign code    = slice[{nib, 2'b00} +: 4];

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state       <= D_IDLE;
            draw_busy_o <= 1'b0;
            gfx_cs_o    <= 1'b0;
            wr_en_o     <= 1'b0;
            col         <= '0;
            nib         <= '0;
        end else begin
            wr_en_o <= 1'b0;
            case (state)
                D_IDLE: if (spr_valid_i) begin
                    draw_busy_o <= 1'b1;
                    col         <= '0;
                    state       <= D_FETCH;
                end
                D_FETCH: if (cols_done) begin
                    draw_busy_o <= 1'b0;
                    state       <= D_IDLE;
                end else begin
                    gfx_cs_o <= 1'b1;
                    state    <= D_WAIT_GFX;
                end
                D_WAIT_GFX: if (gfx_ok_i) begin
                    gfx_cs_o <= 1'b0;
                    nib      <= '0;
                    state    <= D_PLOT;
                end
                D_PLOT: begin
                    wr_en_o <= (code != 4'd0) && (int'(pix_x) < SCREEN_W);
                    nib     <= nib + 1'b1;
                    if (nib == 3'd7) begin
                        col   <= col + 1'b1;
                        state <= D_FETCH;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        if (state == D_IDLE && spr_valid_i) spr_q <= spr_i;
        if (state == D_FETCH && !cols_done) begin
            gfx_req_o.tile   <= spr_q.tile;
            gfx_req_o.offset <= tile_offs;
            gfx_req_o.bank   <= spr_q.bank;
        end
        if (state == D_WAIT_GFX && gfx_ok_i) slice <= gfx_data_i;
        if (state == D_PLOT) begin
            wr_addr_o        <= pix_x;
            wr_pix_o.pri     <= spr_q.pri;
            wr_pix_o.palette <= spr_q.palette;
            wr_pix_o.code    <= code;
        end
    end

    a_req_hold: assert property (@(posedge CLK96) disable iff (RESET96)
        gfx_cs_o && !gfx_ok_i |=> gfx_cs_o && $stable(gfx_req_o))
        else $error("graphics request changed before acknowledge");

endmodule

/* obj_scan/obj_scan.sv */
// attribute RAM scan unit
// reads every entry, applies scroll, line test and y flip,
// queues visible sprites per priority level and hands them
// to the draw unit lowest level first
module obj_scan #(
    parameter int PRI_LEVELS  = obj_cfg_pkg::DEF_PRI_LEVELS,
    parameter int QUEUE_DEPTH = obj_cfg_pkg::DEF_QUEUE_DEPTH
) (
    input  logic                                CLK96,
    input  logic                                RESET96,
    input  logic                                line_start_i,
    input  logic [obj_cfg_pkg::POS_BITS-1:0]    vrender_i,
    input  logic [obj_cfg_pkg::POS_BITS-1:0]    scroll_x_i,
    input  logic [obj_cfg_pkg::POS_BITS-1:0]    scroll_y_i,
    output logic [9:0]                          attr_addr_o,
    input  logic [15:0]                         attr_data_i,
    input  logic                                draw_busy_i,
    output logic                                spr_valid_o,
    output obj_types_pkg::sprite_attr_t         spr_o
);
    import obj_cfg_pkg::*;
    import obj_types_pkg::*;

    localparam int SPR_W  = $clog2(SPRITE_COUNT);
    localparam int WORD_W = $clog2(WORDS_PER_SPRITE);
    localparam int LVL_W  = $clog2(PRI_LEVELS);
    localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);

    scan_state_t              state;
    logic [SPR_W-1:0]         spr_idx;
    logic [WORD_W-1:0]        word_cnt;
    logic [15:0]              w0_q, w1_q, w2_q;      // words 0..2, word 3 used live
    logic [CNT_W-1:0]         level_cnt [PRI_LEVELS];
    logic [PRI_LEVELS-1:0]    level_has;
    logic [LVL_W-1:0]         cur_lvl;
    logic [CNT_W-1:0]         rd_idx;
    sprite_attr_t             queue_mem [PRI_LEVELS*QUEUE_DEPTH];

    logic [POS_BITS-1:0]      y_pos, row_raw;
    logic [7:0]               height;
    logic                     visible, queue_wr, emit;
    logic [LVL_W-1:0]         dec_lvl;
    sprite_attr_t             dec_spr;

    function automatic logic [LVL_W-1:0] lowest_level(input logic [PRI_LEVELS-1:0] has);
        logic [LVL_W-1:0] lvl;
        lvl = '0;
        for (int i = PRI_LEVELS - 1; i >= 0; i--) begin
            if (has[i]) lvl = LVL_W'(i);
        end
        return lvl;
    endfunction

    assign attr_addr_o = {spr_idx, word_cnt};

    // decode while word 3 is on the bus
    assign y_pos   = attr_data_i[15:7] + scroll_y_i;
    assign row_raw = vrender_i - y_pos;
    assign height  = ({4'd0, attr_data_i[3:0]} + 8'd1) * 8'(TILE_PIXELS);
    assign visible = w0_q[15] && (row_raw < {1'b0, height});
    assign dec_lvl = w0_q[8 +: LVL_W];

    always_comb begin
        dec_spr.xflip   = w0_q[12];
        dec_spr.yflip   = w0_q[13];
        dec_spr.pri     = w0_q[11:8];
        dec_spr.palette = w0_q[7:2];
        dec_spr.bank    = w0_q[1:0];
        dec_spr.tile    = w1_q[14:0];
        dec_spr.x_pos   = w2_q[15:7] + scroll_x_i;
        dec_spr.x_size  = w2_q[3:0];
        dec_spr.row     = w0_q[13] ? 7'(height - 8'd1 - row_raw[7:0]) : row_raw[6:0];
    end

    // full levels drop further sprites
    assign queue_wr = (state == S_DECODE) && visible
                      && (level_cnt[dec_lvl] < CNT_W'(QUEUE_DEPTH));
    assign emit     = (state == S_EMIT) && !draw_busy_i && !spr_valid_o
                      && (rd_idx < level_cnt[cur_lvl]);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state       <= S_IDLE;
            spr_idx     <= '0;
            word_cnt    <= '0;
            level_cnt   <= '{default: '0};
            level_has   <= '0;
            cur_lvl     <= '0;
            rd_idx      <= '0;
            spr_valid_o <= 1'b0;
        end else begin
            spr_valid_o <= emit;
            case (state)
                S_IDLE: if (line_start_i) begin
                    spr_idx   <= '0;
                    word_cnt  <= '0;
                    level_cnt <= '{default: '0};
                    level_has <= '0;
                    state     <= S_READ;
                end
                S_READ: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == WORD_W'(WORDS_PER_SPRITE - 1)) state <= S_DECODE;
                end
                S_DECODE: begin
                    if (queue_wr) begin
                        level_cnt[dec_lvl] <= level_cnt[dec_lvl] + 1'b1;
                        level_has[dec_lvl] <= 1'b1;
                    end
                    spr_idx <= spr_idx + 1'b1;
                    state   <= (spr_idx == SPR_W'(SPRITE_COUNT - 1)) ? S_ORDER : S_READ;
                end
                S_ORDER: if (|level_has) begin
                    cur_lvl                          <= lowest_level(level_has);
                    level_has[lowest_level(level_has)] <= 1'b0;
                    rd_idx                           <= '0;
                    state                            <= S_EMIT;
                end else begin
                    state <= S_IDLE;              // line done
                end
                S_EMIT: begin
                    if (emit) rd_idx <= rd_idx + 1'b1;
                    else if (!draw_busy_i && !spr_valid_o) state <= S_ORDER;  // level empty
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // queue memory and handoff register
    always_ff @(posedge CLK96) begin
        case (state)
            S_READ: case (word_cnt)
                WORD_W'(1): w0_q <= attr_data_i;
                WORD_W'(2): w1_q <= attr_data_i;
                WORD_W'(3): w2_q <= attr_data_i;
                default: ;
            endcase
            default: ;
        endcase
        if (queue_wr) queue_mem[int'(dec_lvl) * QUEUE_DEPTH + int'(level_cnt[dec_lvl])] <= dec_spr;
        if (emit) spr_o <= queue_mem[int'(cur_lvl) * QUEUE_DEPTH + int'(rd_idx)];
    end

    for (genvar g = 0; g < PRI_LEVELS; g++) begin : g_cnt_chk
        a_cnt_limit: assert property (@(posedge CLK96) disable iff (RESET96)
            level_cnt[g] <= CNT_W'(QUEUE_DEPTH))
            else $error("priority level %0d queue count overflow", g);
    end

endmodule

/* common/obj_types_pkg.sv */
// object layer data types
// decoded sprite entry, graphics request, line pixel,
// FSM state encodings of the scan and draw units
package obj_types_pkg;

    // one queued sprite as the draw unit sees it
    typedef struct packed {
        logic        xflip;
        logic        yflip;
        logic [3:0]  pri;
        logic [5:0]  palette;
        logic [1:0]  bank;
        logic [14:0] tile;
        logic [8:0]  x_pos;     // scrolled, modulo 512
        logic [3:0]  x_size;    // width in tiles minus one
        logic [6:0]  row;       // row inside the sprite, y flip applied
    } sprite_attr_t;

    // graphics ROM request
    typedef struct packed {
        logic [14:0] tile;
        logic [15:0] offset;
        logic [1:0]  bank;
    } gfx_req_t;

    // line buffer pixel, all zero is transparent
    typedef struct packed {
        logic [3:0] pri;
        logic [5:0] palette;
        logic [3:0] code;
    } obj_pixel_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_DECODE,
        S_ORDER,
        S_EMIT
    } scan_state_t;

    typedef enum logic [1:0] {
        D_IDLE,
        D_FETCH,
        D_WAIT_GFX,
        D_PLOT
    } draw_state_t;

endpackage

/* common/obj_cfg_pkg.sv */
// object layer geometry and sizing constants
// attribute RAM layout, line buffer length, tile slice size,
// default screen width and priority queue sizes
package obj_cfg_pkg;

    // attribute RAM
    localparam int SPRITE_COUNT     = 256;
    localparam int WORDS_PER_SPRITE = 4;   // 16-bit words per entry

    // screen and queue defaults, overridable at the top level
    localparam int DEF_SCREEN_W     = 320;
    localparam int DEF_PRI_LEVELS   = 16;
    localparam int DEF_QUEUE_DEPTH  = 16;

    // line memory
    localparam int LINE_W           = 512;
    localparam int POS_BITS         = 9;   // screen coordinates wrap at 512

    // graphics slices
    localparam int TILE_PIXELS      = 8;   // one 32-bit word, 4 bits per pixel
    localparam int SLICE_STRIDE     = 32;  // offset units per tile column block

endpackage
